// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  // Datapath sizes
  localparam int data_w    = 16;
  localparam int reg_idx_w = 4;
  localparam int num_regs  = 16;

  // Opcodes kept from the base ISA
  localparam logic [3:0] op_add = 4'h0;
  localparam logic [3:0] op_sub = 4'h1;
  localparam logic [3:0] op_xor = 4'h2;
  localparam logic [3:0] op_sll = 4'h4;
  localparam logic [3:0] op_sra = 4'h5;
  localparam logic [3:0] op_ror = 4'h6;
  localparam logic [3:0] op_llb = 4'ha;
  localparam logic [3:0] op_lhb = 4'hb;

  // APB byte offsets
  // Status write issues, status read gives Z V N in bits 2..0
  localparam int status_off   = 0;
  // Register n sits at reg_base_off + 4*n
  localparam int reg_base_off = 64;

  // One instruction word, two layouts
  typedef union packed {
    struct packed {
      logic [3:0] opcode;
      logic [3:0] rd;
      logic [3:0] rs;
      // Second source, or shift amount for SLL/SRA/ROR
      logic [3:0] rt;
    } r_view;
    struct packed {
      logic [3:0] opcode;
      logic [3:0] rd;
      logic [7:0] imm8;
    } i_view;
  } inst_word_u;

  // Opcodes this core executes
  function automatic logic op_legal(input logic [3:0] op);
    logic legal;
    case (op)
      op_add, op_sub, op_xor, op_sll, op_sra, op_ror, op_llb, op_lhb: legal = 1'b1;
      default: legal = 1'b0;
    endcase
    return legal;
  endfunction

endpackage

// ==== design/apb_port.sv ====
`timescale 1ns/1ps

module apb_port import cpu_pkg::*; #(
  parameter int addr_w = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [addr_w-1:0]    paddr,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  logic [data_w-1:0]    pwdata,
  input  logic                 busy,
  input  logic [2:0]           flags,
  input  logic [data_w-1:0]    reg_rdata,
  output logic [data_w-1:0]    prdata,
  output logic                 pready,
  output logic                 pslverr,
  output logic                 issue_valid,
  output inst_word_u           issue_inst,
  output logic [reg_idx_w-1:0] rd_sel
);

  logic [addr_w-1:0] reg_off;
  logic              is_status;
  logic              is_reg;
  logic              decide;
  logic              rd_go;
  inst_word_u        wr_inst;

  // Offset decode
  assign is_status = (paddr == addr_w'(status_off));
  assign reg_off   = paddr - addr_w'(reg_base_off);
  // Below-base addresses wrap high and miss this window
  assign is_reg    = (reg_off < addr_w'(4 * num_regs)) && (reg_off[1:0] == 2'b00);
  assign rd_sel    = reg_off[reg_idx_w+1:2];
  assign wr_inst   = pwdata;

  // Selected and no response given yet
  // Covers the setup cycle and any waiting access cycles
  assign decide = psel && !pready;
  // Read data sampled once the pipeline is empty
  assign rd_go  = decide && !pwrite && !busy;

  // Response FSM
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pready      <= 1'b0;
      pslverr     <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= 1'b0;
      if (pready) begin
        // Access cycle with response, transfer ends here
        pready  <= 1'b0;
        pslverr <= 1'b0;
      end else if (decide) begin
        if (!is_status && !is_reg) begin
          // Unmapped, error with no effect
          pready  <= 1'b1;
          pslverr <= 1'b1;
        end else if (pwrite) begin
          // No wait state on writes
          pready <= 1'b1;
          // Register slots ignore writes
          if (is_status) begin
            if (op_legal(wr_inst.r_view.opcode)) begin
              issue_valid <= 1'b1;
            end else begin
              pslverr <= 1'b1;
            end
          end
        end else if (!busy) begin
          pready <= 1'b1;
        end
      end
    end
  end

  // Instruction and read data payload
  always_ff @(posedge clk) begin
    if (decide && pwrite && is_status) begin
      issue_inst <= wr_inst;
    end
    if (rd_go) begin
      prdata <= is_status ? {{(data_w-3){1'b0}}, flags} : (is_reg ? reg_rdata : '0);
    end
  end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [reg_idx_w-1:0] rs_a,
  input  logic [reg_idx_w-1:0] rs_b,
  input  logic [reg_idx_w-1:0] rd_sel,
  input  logic                 wb_en,
  input  logic [reg_idx_w-1:0] wb_rd,
  input  logic [data_w-1:0]    wb_data,
  output logic [data_w-1:0]    rd_data_a,
  output logic [data_w-1:0]    rd_data_b,
  output logic [data_w-1:0]    reg_rdata
);

  logic [data_w-1:0] regs [num_regs];

  // Operand read, r0 zero, same-cycle write passed through
  function automatic logic [data_w-1:0] read_port(input logic [reg_idx_w-1:0] idx);
    logic [data_w-1:0] val;
    if (idx == '0) begin
      val = '0;
    end else if (wb_en && (wb_rd == idx)) begin
      val = wb_data;
    end else begin
      val = regs[idx];
    end
    return val;
  endfunction

  // Write port, r0 never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && (wb_rd != '0)) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // Decode-stage operands
  always_comb begin
    rd_data_a = read_port(rs_a);
    rd_data_b = read_port(rs_b);
  end

  // APB read port, only sampled with the pipeline drained
  assign reg_rdata = regs[rd_sel];

endmodule

// ==== design/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 issue_valid,
  input  inst_word_u           issue_inst,
  input  logic [data_w-1:0]    rd_data_a,
  input  logic [data_w-1:0]    rd_data_b,
  output logic [reg_idx_w-1:0] rs_a,
  output logic [reg_idx_w-1:0] rs_b,
  output logic                 ex_valid,
  output logic [3:0]           ex_op,
  output logic [reg_idx_w-1:0] ex_rd,
  output logic [data_w-1:0]    ex_a,
  output logic [data_w-1:0]    ex_b,
  output logic [data_w-1:0]    ex_imm
);

  inst_word_u dec_inst;
  logic [3:0] opcode;
  logic       is_byte;
  logic       is_shift;

  // Decode stage valid
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= issue_valid;
    end
  end

  // Issued word
  always_ff @(posedge clk) begin
    dec_inst <= issue_inst;
  end

  // Opcode sits in the same bits in both layouts
  assign opcode   = dec_inst.r_view.opcode;
  assign is_byte  = (opcode == op_llb) || (opcode == op_lhb);
  assign is_shift = (opcode == op_sll) || (opcode == op_sra) || (opcode == op_ror);

  // First source is rs, unused by byte loads
  assign rs_a = dec_inst.r_view.rs;
  // Byte loads fetch old rd as second source
  assign rs_b = is_byte ? dec_inst.i_view.rd : dec_inst.r_view.rt;

  assign ex_op = opcode;
  // Destination shares its bits in both layouts
  assign ex_rd = dec_inst.r_view.rd;

  // Operands go straight into the execute stage register
  // Bypass from write-back already applied by the register file
  assign ex_a = rd_data_a;
  assign ex_b = rd_data_b;

  // Immediate build
  always_comb begin
    ex_imm = '0;
    if (is_shift) begin
      // Shift amount in the rt slot
      ex_imm = {{(data_w-4){1'b0}}, dec_inst.r_view.rt};
    end else if (opcode == op_llb) begin
      ex_imm = {8'h00, dec_inst.i_view.imm8};
    end else if (opcode == op_lhb) begin
      ex_imm = {dec_inst.i_view.imm8, 8'h00};
    end
  end

endmodule

// ==== design/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 ex_valid,
  input  logic [3:0]           ex_op,
  input  logic [reg_idx_w-1:0] ex_rd,
  input  logic [data_w-1:0]    ex_a,
  input  logic [data_w-1:0]    ex_b,
  input  logic [data_w-1:0]    ex_imm,
  output logic                 res_valid,
  output logic                 res_wen,
  output logic [reg_idx_w-1:0] res_rd,
  output logic [data_w-1:0]    res_data,
  output logic [2:0]           res_flags,
  output logic [2:0]           res_flag_mask
);

  logic                 x_valid;
  logic [3:0]           x_op;
  logic [reg_idx_w-1:0] x_rd;
  logic [data_w-1:0]    x_a;
  logic [data_w-1:0]    x_b;
  logic [data_w-1:0]    x_imm;
  logic [3:0]           shamt;
  logic [data_w-1:0]    sum;
  logic [data_w-1:0]    diff;
  logic [data_w-1:0]    sat_val;
  logic [2*data_w-1:0]  rot;
  logic                 sum_ovf;
  logic                 diff_ovf;
  logic                 sat;

  // Execute stage register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_valid <= 1'b0;
    end else begin
      x_valid <= ex_valid;
    end
  end

  always_ff @(posedge clk) begin
    x_op  <= ex_op;
    x_rd  <= ex_rd;
    x_a   <= ex_a;
    x_b   <= ex_b;
    x_imm <= ex_imm;
  end

  assign shamt = x_imm[3:0];
  assign sum   = x_a + x_b;
  assign diff  = x_a - x_b;

  // Signed overflow checks
  assign sum_ovf  = (x_a[data_w-1] == x_b[data_w-1]) && (sum[data_w-1] != x_a[data_w-1]);
  assign diff_ovf = (x_a[data_w-1] != x_b[data_w-1]) && (diff[data_w-1] != x_a[data_w-1]);
  // Overflow always runs toward the sign of a
  assign sat_val  = {x_a[data_w-1], {(data_w-1){~x_a[data_w-1]}}};

  // Rotate via doubled word
  assign rot = {x_a, x_a} >> shamt;

  always_comb begin
    sat           = 1'b0;
    res_data      = '0;
    res_flag_mask = 3'b000;
    case (x_op)
      op_add: begin
        sat           = sum_ovf;
        res_data      = sum_ovf ? sat_val : sum;
        res_flag_mask = 3'b111;
      end
      op_sub: begin
        sat           = diff_ovf;
        res_data      = diff_ovf ? sat_val : diff;
        res_flag_mask = 3'b111;
      end
      op_xor: begin
        res_data      = x_a ^ x_b;
        res_flag_mask = 3'b100;
      end
      op_sll: begin
        res_data      = x_a << shamt;
        res_flag_mask = 3'b100;
      end
      op_sra: begin
        res_data      = $signed(x_a) >>> shamt;
        res_flag_mask = 3'b100;
      end
      op_ror: begin
        res_data      = rot[data_w-1:0];
        res_flag_mask = 3'b100;
      end
      // Byte loads merge into old rd, flags untouched
      op_llb: res_data = (x_b & 16'hff00) | x_imm;
      op_lhb: res_data = (x_b & 16'h00ff) | x_imm;
      default: res_data = '0;
    endcase
  end

  // Z V N, masked later in the result stage
  assign res_flags = {(res_data == '0), sat, res_data[data_w-1]};

  assign res_valid = x_valid;
  // No write-back for r0
  assign res_wen   = x_valid && (x_rd != '0);
  assign res_rd    = x_rd;

endmodule

// ==== design/result_stage.sv ====
`timescale 1ns/1ps

module result_stage import cpu_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 res_valid,
  input  logic                 res_wen,
  input  logic [reg_idx_w-1:0] res_rd,
  input  logic [data_w-1:0]    res_data,
  input  logic [2:0]           res_flags,
  input  logic [2:0]           res_flag_mask,
  output logic                 wb_en,
  output logic [reg_idx_w-1:0] wb_rd,
  output logic [data_w-1:0]    wb_data,
  output logic [2:0]           flags,
  output logic                 busy_res
);

  logic                 r_valid;
  logic                 r_wen;
  logic [reg_idx_w-1:0] r_rd;
  logic [data_w-1:0]    r_data;
  logic [2:0]           r_flags;
  logic [2:0]           r_mask;

  // Result stage valid and flag register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_valid <= 1'b0;
      r_wen   <= 1'b0;
      flags   <= 3'b000;
    end else begin
      r_valid <= res_valid;
      r_wen   <= res_wen;
      // Flags land with the register write
      if (r_valid) begin
        for (int i = 0; i < 3; i++) begin
          if (r_mask[i]) begin
            flags[i] <= r_flags[i];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    r_rd    <= res_rd;
    r_data  <= res_data;
    r_flags <= res_flags;
    r_mask  <= res_flag_mask;
  end

  // Write-back
  assign wb_en    = r_valid && r_wen;
  assign wb_rd    = r_rd;
  assign wb_data  = r_data;
  assign busy_res = r_valid;

endmodule

// ==== design/cpu_core_top.sv ====
`timescale 1ns/1ps

module cpu_core_top import cpu_pkg::*; #(
  parameter int addr_w = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [addr_w-1:0] paddr,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  logic [data_w-1:0] pwdata,
  output logic [data_w-1:0] prdata,
  output logic              pready,
  output logic              pslverr
);

  // APB to decode
  logic                 issue_valid;
  inst_word_u           issue_inst;
  logic [reg_idx_w-1:0] rd_sel;
  logic [data_w-1:0]    reg_rdata;
  // Register file operand ports
  logic [reg_idx_w-1:0] rs_a;
  logic [reg_idx_w-1:0] rs_b;
  logic [data_w-1:0]    rd_data_a;
  logic [data_w-1:0]    rd_data_b;
  // Decode to execute
  logic                 ex_valid;
  logic [3:0]           ex_op;
  logic [reg_idx_w-1:0] ex_rd;
  logic [data_w-1:0]    ex_a;
  logic [data_w-1:0]    ex_b;
  logic [data_w-1:0]    ex_imm;
  // Execute to result
  logic                 res_valid;
  logic                 res_wen;
  logic [reg_idx_w-1:0] res_rd;
  logic [data_w-1:0]    res_data;
  logic [2:0]           res_flags;
  logic [2:0]           res_flag_mask;
  // Write-back and status
  logic                 wb_en;
  logic [reg_idx_w-1:0] wb_rd;
  logic [data_w-1:0]    wb_data;
  logic [2:0]           flags;
  logic                 busy_res;
  logic                 busy;

  // Any stage holding an instruction
  assign busy = ex_valid | res_valid | busy_res;

  apb_port #(.addr_w(addr_w)) u_apb (
    .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .busy(busy), .flags(flags),
    .reg_rdata(reg_rdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .issue_valid(issue_valid), .issue_inst(issue_inst), .rd_sel(rd_sel)
  );

  reg_file u_regs (
    .clk(clk), .rst_n(rst_n), .rs_a(rs_a), .rs_b(rs_b), .rd_sel(rd_sel),
    .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .reg_rdata(reg_rdata)
  );

  inst_decode u_decode (
    .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_inst(issue_inst),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .rs_a(rs_a), .rs_b(rs_b),
    .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd), .ex_a(ex_a), .ex_b(ex_b),
    .ex_imm(ex_imm)
  );

  alu_execute u_execute (
    .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_op(ex_op), .ex_rd(ex_rd),
    .ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm), .res_valid(res_valid),
    .res_wen(res_wen), .res_rd(res_rd), .res_data(res_data), .res_flags(res_flags),
    .res_flag_mask(res_flag_mask)
  );

  result_stage u_result (
    .clk(clk), .rst_n(rst_n), .res_valid(res_valid), .res_wen(res_wen),
    .res_rd(res_rd), .res_data(res_data), .res_flags(res_flags),
    .res_flag_mask(res_flag_mask), .wb_en(wb_en), .wb_rd(wb_rd), .wb_data(wb_data),
    .flags(flags), .busy_res(busy_res)
  );

endmodule

// ==== bench/cpu_chk.sv ====
`timescale 1ns/1ps

module cpu_chk (
  input logic clk,
  input logic rst_n,
  input logic psel,
  input logic penable,
  input logic pwrite,
  input logic pready,
  input logic pslverr,
  input logic busy,
  input logic issue_valid
);

  // Response only inside the access phase
  assert property (@(posedge clk) disable iff (!rst_n) pready |-> (psel && penable))
    else $error("pready high outside the APB access phase");

  // A rejected instruction is never issued
  assert property (@(posedge clk) disable iff (!rst_n) !(issue_valid && pslverr))
    else $error("issue_valid together with pslverr");

  // Pending read held while the pipeline is busy
  assert property (@(posedge clk) disable iff (!rst_n)
    (psel && !pwrite && !pready && busy) |=> !pready)
    else $error("read completed while the pipeline was busy");

endmodule

bind apb_port cpu_chk u_chk (
  .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
  .pready(pready), .pslverr(pslverr), .busy(busy), .issue_valid(issue_valid)
);

// ==== bench/cpu_monitor.sv ====
`timescale 1ns/1ps

module cpu_monitor (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic        pready,
  input  logic        pslverr,
  input  logic [15:0] prdata,
  input  logic        exp_err,
  input  logic        exp_chk_data,
  input  logic [15:0] exp_data,
  output int          n_tests,
  output int          n_errors
);

  logic bad;

  initial begin
    n_tests  = 0;
    n_errors = 0;
  end

  // pready lasts one cycle, so each transfer is seen at exactly one negedge
  always @(negedge clk) begin
    if (rst_n && psel && penable && pready) begin
      bad = 1'b0;
      n_tests = n_tests + 1;
      if (pslverr !== exp_err) begin
        $display("FAIL t=%0t pslverr got %b expected %b", $time, pslverr, exp_err);
        bad = 1'b1;
      end
      // Read data only compared on mapped reads
      if (!pwrite && exp_chk_data && (prdata !== exp_data)) begin
        $display("FAIL t=%0t prdata got %h expected %h", $time, prdata, exp_data);
        bad = 1'b1;
      end
      if (bad) begin
        n_errors = n_errors + 1;
      end else if (pwrite) begin
        $display("ok   test %0d write err=%b", n_tests, pslverr);
      end else begin
        $display("ok   test %0d read data=%h err=%b", n_tests, prdata, pslverr);
      end
    end
  end

endmodule

// ==== bench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

  localparam int n_rand = 24;
  localparam logic [7:0] st = 8'h00;

  logic        clk;
  logic        rst_n;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [15:0] pwdata;
  logic [15:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        exp_err;
  logic        exp_chk_data;
  logic [15:0] exp_data;
  int          n_tests;
  int          n_errors;
  int          n_expected;
  logic        table_built;

  // Stimulus table, one field per queue
  logic        t_wen[$];
  logic [7:0]  t_waddr[$];
  logic [15:0] t_inst[$];
  logic        t_werr[$];
  logic        t_ren[$];
  logic [7:0]  t_raddr[$];
  logic        t_rerr[$];
  logic [15:0] t_exp[$];

  logic [31:0] rng_state;
  logic [2:0]  flags_m;

  cpu_core_top #(.addr_w(8)) u_dut (
    .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr)
  );

  cpu_monitor u_mon (
    .clk(clk), .rst_n(rst_n), .psel(psel), .penable(penable), .pwrite(pwrite),
    .pready(pready), .pslverr(pslverr), .prdata(prdata), .exp_err(exp_err),
    .exp_chk_data(exp_chk_data), .exp_data(exp_data), .n_tests(n_tests),
    .n_errors(n_errors)
  );

  always #50 clk = ~clk;

  function automatic logic [7:0] reg_addr(input int n);
    return 8'(reg_base_off + 4 * n);
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Behavioral ALU, also updates the flag model
  task automatic alu_model(input logic [3:0] op, input logic [15:0] a,
                           input logic [15:0] b, input logic [3:0] sh,
                           output logic [15:0] res);
    int   s;
    logic v;
    v = 1'b0;
    s = 0;
    res = 16'h0000;
    if (op == op_add || op == op_sub) begin
      if (op == op_add) s = int'($signed(a)) + int'($signed(b));
      else s = int'($signed(a)) - int'($signed(b));
      if (s > 32767) begin
        res = 16'h7fff;
        v = 1'b1;
      end else if (s < -32768) begin
        res = 16'h8000;
        v = 1'b1;
      end else begin
        res = s[15:0];
      end
      flags_m = {res == 16'h0000, v, res[15]};
    end else begin
      case (op)
        op_xor: res = a ^ b;
        op_sll: res = a << sh;
        op_sra: res = 16'($signed(a) >>> sh);
        default: res = (a >> sh) | 16'({a, 16'h0000} >> sh);
      endcase
      flags_m[2] = (res == 16'h0000);
    end
  endtask

  // One APB transfer, starting just after a rising edge
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
                          input logic err, input logic chk, input logic [15:0] exp);
    psel         = 1'b1;
    penable      = 1'b0;
    pwrite       = wr;
    paddr        = addr;
    pwdata       = wdata;
    exp_err      = err;
    exp_chk_data = chk;
    exp_data     = exp;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    while (!pready) @(negedge clk);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    n_expected = n_expected + 1;
  endtask

  task automatic add_entry(input logic wen, input logic [7:0] waddr, input logic [15:0] inst,
                           input logic werr, input logic ren, input logic [7:0] raddr,
                           input logic rerr, input logic [15:0] exp);
    t_wen.push_back(wen);
    t_waddr.push_back(waddr);
    t_inst.push_back(inst);
    t_werr.push_back(werr);
    t_ren.push_back(ren);
    t_raddr.push_back(raddr);
    t_rerr.push_back(rerr);
    t_exp.push_back(exp);
  endtask

  task automatic build_table();
    // Byte loads build full words
    add_entry(1, st, 16'ha134, 0, 1, reg_addr(1), 0, 16'h0034);
    add_entry(1, st, 16'hb112, 0, 1, reg_addr(1), 0, 16'h1234);
    add_entry(1, st, 16'hb27f, 0, 1, reg_addr(2), 0, 16'h7f00);
    add_entry(1, st, 16'ha2ff, 0, 1, reg_addr(2), 0, 16'h7fff);
    // Positive saturation, Z V N = 010
    add_entry(1, st, 16'h0322, 0, 1, reg_addr(3), 0, 16'h7fff);
    add_entry(0, st, 16'h0000, 0, 1, st, 0, 16'h0002);
    add_entry(1, st, 16'hb480, 0, 1, reg_addr(4), 0, 16'h8000);
    // Negative saturation on SUB
    add_entry(1, st, 16'h1542, 0, 1, reg_addr(5), 0, 16'h8000);
    add_entry(0, st, 16'h0000, 0, 1, st, 0, 16'h0003);
    add_entry(1, st, 16'h1611, 0, 1, st, 0, 16'h0004);
    add_entry(1, st, 16'h1542, 0, 1, st, 0, 16'h0003);
    // Logic ops touch Z only
    add_entry(1, st, 16'h2711, 0, 1, st, 0, 16'h0007);
    add_entry(1, st, 16'h2712, 0, 1, reg_addr(7), 0, 16'h6dcb);
    add_entry(0, st, 16'h0000, 0, 1, st, 0, 16'h0003);
    add_entry(1, st, 16'h4814, 0, 1, reg_addr(8), 0, 16'h2340);
    add_entry(1, st, 16'h5943, 0, 1, reg_addr(9), 0, 16'hf000);
    add_entry(1, st, 16'h6a14, 0, 1, reg_addr(10), 0, 16'h4123);
    add_entry(0, st, 16'h0000, 0, 1, st, 0, 16'h0003);
    // Back-to-back dependent pair
    add_entry(1, st, 16'h0b11, 0, 0, st, 0, 16'h0000);
    add_entry(1, st, 16'h0cb1, 0, 1, reg_addr(12), 0, 16'h369c);
    add_entry(1, st, 16'h0d44, 0, 1, reg_addr(13), 0, 16'h8000);
    add_entry(0, st, 16'h0000, 0, 1, st, 0, 16'h0003);
    // Illegal opcodes and unmapped addresses
    add_entry(1, st, 16'h3712, 1, 1, reg_addr(7), 0, 16'h6dcb);
    add_entry(1, st, 16'hf1ff, 1, 1, reg_addr(1), 0, 16'h1234);
    add_entry(1, 8'h08, 16'ha1aa, 1, 1, reg_addr(1), 0, 16'h1234);
    add_entry(0, st, 16'h0000, 0, 1, 8'h04, 1, 16'h0000);
    add_entry(0, st, 16'h0000, 0, 1, 8'h46, 1, 16'h0000);
    // r0 stays zero
    add_entry(1, st, 16'ha055, 0, 1, reg_addr(0), 0, 16'h0000);
    add_entry(1, st, 16'h0011, 0, 1, reg_addr(0), 0, 16'h0000);
    add_entry(0, st, 16'h0000, 0, 1, st, 0, 16'h0000);
  endtask

  task automatic run_random();
    logic [3:0]  ops [6];
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] res;
    logic [3:0]  op;
    logic [3:0]  sh;
    ops = '{op_add, op_sub, op_xor, op_sll, op_sra, op_ror};
    // Last table op leaves Z V N at 000
    flags_m = 3'b000;
    for (int i = 0; i < n_rand; i++) begin
      rng_state = xorshift32(rng_state);
      a = rng_state[15:0];
      b = rng_state[31:16];
      rng_state = xorshift32(rng_state);
      op = ops[rng_state[7:0] % 6];
      sh = rng_state[11:8];
      apb_xfer(1, st, {op_llb, 4'd1, a[7:0]}, 0, 0, 16'h0000);
      apb_xfer(1, st, {op_lhb, 4'd1, a[15:8]}, 0, 0, 16'h0000);
      apb_xfer(1, st, {op_llb, 4'd2, b[7:0]}, 0, 0, 16'h0000);
      apb_xfer(1, st, {op_lhb, 4'd2, b[15:8]}, 0, 0, 16'h0000);
      alu_model(op, a, b, sh, res);
      if (op == op_sll || op == op_sra || op == op_ror) begin
        apb_xfer(1, st, {op, 4'd3, 4'd1, sh}, 0, 0, 16'h0000);
      end else begin
        apb_xfer(1, st, {op, 4'd3, 4'd1, 4'd2}, 0, 0, 16'h0000);
      end
      apb_xfer(0, reg_addr(3), 16'h0000, 0, 1, res);
      apb_xfer(0, st, 16'h0000, 0, 1, {13'h0000, flags_m});
    end
  endtask

  // Watchdog sized from the table and the random phase
  initial begin
    wait (table_built);
    repeat (t_inst.size() * 20 + n_rand * 20 + 10) @(posedge clk);
    $display("Timeout: the run did not finish in the expected number of cycles");
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    paddr        = 8'h00;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    pwdata       = 16'h0000;
    exp_err      = 1'b0;
    exp_chk_data = 1'b0;
    exp_data     = 16'h0000;
    n_expected   = 0;
    table_built  = 1'b0;
    rng_state    = 32'hd3575346;
    build_table();
    table_built = 1'b1;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;
    for (int i = 0; i < t_inst.size(); i++) begin
      if (t_wen[i]) apb_xfer(1, t_waddr[i], t_inst[i], t_werr[i], 0, 16'h0000);
      if (t_ren[i]) apb_xfer(0, t_raddr[i], 16'h0000, t_rerr[i], !t_rerr[i], t_exp[i]);
    end
    run_random();
    repeat (2) @(posedge clk);
    $display("tests %0d of %0d, errors %0d", n_tests, n_expected, n_errors);
    if (n_errors == 0 && n_tests == n_expected) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// ==== list.f ====
design/cpu_pkg.sv
design/apb_port.sv
design/reg_file.sv
design/inst_decode.sv
design/alu_execute.sv
design/result_stage.sv
design/cpu_core_top.sv
bench/cpu_chk.sv
bench/cpu_monitor.sv
bench/cpu_tb.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim
	./obj_dir/cpu_sim | tee $(LOG)
	grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
